// File: logic/sifhPkg.sv
package sifhPkg;

    // timestamp and bin geometry
    localparam int STAMP_W = 10;
    localparam int BIN_W = 4;
    localparam int BIN_NUM = 16;

    // frame geometry, pixel-major
    localparam int PIXEL_NUM = 4;
    localparam int PIX_W = 2;
    localparam int ACQ_NUM = 80;
    localparam int ACQ_W = $clog2(ACQ_NUM);

    // histogram storage
    localparam int COUNT_W = 6;
    localparam int COUNT_MAX = 63;
    localparam int RAM_DEPTH = 64;
    localparam int ADDR_W = 6;

    // cycles to let the last updates land before scanning
    localparam int DRAIN_CYC = 2;

    typedef logic [STAMP_W-1:0] stampT;
    typedef logic [BIN_W-1:0]   binT;
    typedef logic [PIX_W-1:0]   pixelT;
    // pixel in the upper bits, bin in the lower
    typedef logic [ADDR_W-1:0]  addrT;
    typedef logic [COUNT_W-1:0] countT;

    typedef enum logic [1:0] {CLEAR, ACCUM, DRAIN, SCAN} ctrlStateT;

    typedef struct packed {
        logic  rdEn;
        addrT  rdAddr;
        logic  wrEn;
        addrT  wrAddr;
        countT wrData;
    } ramReqT;

    typedef struct packed {
        logic  valid;
        pixelT pixel;
        binT   bin;
        logic  last;
    } scanTagT;

    typedef struct packed {
        pixelT pixel;
        binT   bin;
        countT count;
    } peakT;

endpackage

// File: logic/histRam.sv
`timescale 1ns/1ps

module histRam import sifhPkg::*; (
    input  logic   clk,
    input  ramReqT req,
    output countT  rdData
);

    // one count per pixel and bin
    countT mem [RAM_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (req.wrEn) begin
            mem[req.wrAddr] <= req.wrData;
        end
    end

    // registered read port
    // same-address collision returns the old word
    always_ff @(posedge clk) begin
        if (req.rdEn) begin
            rdData <= mem[req.rdAddr];
        end
    end

endmodule

// File: logic/countUpdater.sv
`timescale 1ns/1ps

module countUpdater import sifhPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   updValid,
    input  addrT   updAddr,
    input  countT  ramData,
    output ramReqT req
);

    // sample whose read is returning this cycle
    logic  pendValid;
    addrT  pendAddr;

    // word written in the previous cycle
    logic  lastWrValid;
    addrT  lastWrAddr;
    countT lastWrData;

    countT oldCount;
    countT newCount;
    logic  fwdHit;

    // RAM still holds the stale value when the previous
    // write went to the same address
    assign fwdHit = lastWrValid && (lastWrAddr == pendAddr);

    always_comb begin
        oldCount = fwdHit ? lastWrData : ramData;
        // saturating increment
        if (oldCount == countT'(COUNT_MAX)) begin
            newCount = oldCount;
        end else begin
            newCount = oldCount + countT'(1);
        end
    end

    // write for the pending sample plus read for the new one
    always_comb begin
        req.rdEn   = updValid;
        req.rdAddr = updAddr;
        req.wrEn   = pendValid;
        req.wrAddr = pendAddr;
        req.wrData = newCount;
    end

    // pipeline valids
    always_ff @(posedge clk) begin
        if (rst) begin
            pendValid   <= 1'b0;
            lastWrValid <= 1'b0;
        end else begin
            pendValid   <= updValid;
            lastWrValid <= pendValid;
        end
    end

    // addresses and forwarded data
    always_ff @(posedge clk) begin
        pendAddr   <= updAddr;
        lastWrAddr <= pendAddr;
        lastWrData <= newCount;
    end

endmodule

// File: logic/peakFinder.sv
`timescale 1ns/1ps

module peakFinder import sifhPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  scanTagT scanTag,
    input  countT   ramData,
    output logic    peakValid,
    output peakT    peak
);

    // running best of the pixel being scanned
    binT   bestBin;
    countT bestCount;

    // best including the current bin
    logic  takeNew;
    binT   candBin;
    countT candCount;

    // bin 0 always loads
    // later bins need a strictly greater count, so ties keep the lower bin
    assign takeNew = (scanTag.bin == '0) || (ramData > bestCount);

    always_comb begin
        if (takeNew) begin
            candBin   = scanTag.bin;
            candCount = ramData;
        end else begin
            candBin   = bestBin;
            candCount = bestCount;
        end
    end

    always_ff @(posedge clk) begin
        if (scanTag.valid) begin
            bestBin   <= candBin;
            bestCount <= candCount;
        end
    end

    // result register, loaded on the last bin of a pixel
    always_ff @(posedge clk) begin
        if (scanTag.valid && scanTag.last) begin
            peak.pixel <= scanTag.pixel;
            peak.bin   <= candBin;
            peak.count <= candCount;
        end
    end

    // one pulse per pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= scanTag.valid && scanTag.last;
        end
    end

endmodule

// File: logic/histControl.sv
`timescale 1ns/1ps

module histControl import sifhPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    sampleValid,
    input  stampT   sample,
    output logic    ready,
    output logic    updValid,
    output addrT    updAddr,
    input  ramReqT  updReq,
    output ramReqT  ramReq,
    output scanTagT scanTag
);

    ctrlStateT state;
    ctrlStateT stateNext;

    // position within the frame
    logic [ACQ_W-1:0] acqCnt;
    pixelT            pixCnt;

    // shared clear and scan address
    addrT memAddr;
    logic drainCnt;

    logic accept;
    logic acqLast;
    logic pixLast;
    logic frameEnd;
    logic memLast;

    // samples only count while accumulating
    assign ready    = (state == ACCUM);
    assign accept   = ready && sampleValid;
    assign acqLast  = (acqCnt == ACQ_W'(ACQ_NUM - 1));
    assign pixLast  = (pixCnt == PIX_W'(PIXEL_NUM - 1));
    assign frameEnd = accept && acqLast && pixLast;
    assign memLast  = (memAddr == ADDR_W'(RAM_DEPTH - 1));

    // bin is the top of the timestamp
    assign updValid = accept;
    assign updAddr  = {pixCnt, sample[STAMP_W-1 -: BIN_W]};

    always_comb begin
        stateNext = state;
        case (state)
            CLEAR: if (memLast) stateNext = ACCUM;
            ACCUM: if (frameEnd) stateNext = DRAIN;
            // wait out the updater pipeline
            DRAIN: if (drainCnt == 1'(DRAIN_CYC - 1)) stateNext = SCAN;
            SCAN:  if (memLast) stateNext = ACCUM;
            default: stateNext = CLEAR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= CLEAR;
            acqCnt   <= '0;
            pixCnt   <= '0;
            memAddr  <= '0;
            drainCnt <= 1'b0;
        end else begin
            state <= stateNext;
            // sample and pixel counters
            if (accept) begin
                if (acqLast) begin
                    acqCnt <= '0;
                    pixCnt <= pixLast ? '0 : pixCnt + pixelT'(1);
                end else begin
                    acqCnt <= acqCnt + ACQ_W'(1);
                end
            end
            // address walks 0..63 in clear and scan
            if (state == CLEAR || state == SCAN) begin
                memAddr <= memLast ? '0 : memAddr + addrT'(1);
            end
            drainCnt <= (state == DRAIN) ? drainCnt + 1'b1 : 1'b0;
        end
    end

    // RAM port select
    always_comb begin
        ramReq = updReq;
        case (state)
            CLEAR: begin
                ramReq.rdEn   = 1'b0;
                ramReq.rdAddr = memAddr;
                ramReq.wrEn   = 1'b1;
                ramReq.wrAddr = memAddr;
                ramReq.wrData = '0;
            end
            // read a bin and zero it in the same cycle
            SCAN: begin
                ramReq.rdEn   = 1'b1;
                ramReq.rdAddr = memAddr;
                ramReq.wrEn   = 1'b1;
                ramReq.wrAddr = memAddr;
                ramReq.wrData = '0;
            end
            default: ramReq = updReq;
        endcase
    end

    // tag lines up with the RAM read data
    always_ff @(posedge clk) begin
        if (rst) begin
            scanTag <= '0;
        end else begin
            scanTag.valid <= (state == SCAN);
            scanTag.pixel <= memAddr[ADDR_W-1 -: PIX_W];
            scanTag.bin   <= memAddr[BIN_W-1:0];
            scanTag.last  <= (state == SCAN) && (memAddr[BIN_W-1:0] == BIN_W'(BIN_NUM - 1));
        end
    end

endmodule

// File: logic/sifhTop.sv
`timescale 1ns/1ps

module sifhTop import sifhPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  sampleValid,
    input  stampT sample,
    output logic  ready,
    output logic  peakValid,
    output peakT  peak
);

    // control to updater
    logic    updValid;
    addrT    updAddr;
    ramReqT  updReq;

    // RAM side
    ramReqT  ramReq;
    countT   ramData;

    // control to peak finder
    scanTagT scanTag;

    // frame FSM and RAM arbitration
    histControl control (
        .clk         (clk),
        .rst         (rst),
        .sampleValid (sampleValid),
        .sample      (sample),
        .ready       (ready),
        .updValid    (updValid),
        .updAddr     (updAddr),
        .updReq      (updReq),
        .ramReq      (ramReq),
        .scanTag     (scanTag)
    );

    // read-modify-write of the counts
    countUpdater updater (
        .clk      (clk),
        .rst      (rst),
        .updValid (updValid),
        .updAddr  (updAddr),
        .ramData  (ramData),
        .req      (updReq)
    );

    // histogram storage
    histRam ram (
        .clk    (clk),
        .req    (ramReq),
        .rdData (ramData)
    );

    // per-pixel peak search during the scan
    peakFinder finder (
        .clk       (clk),
        .rst       (rst),
        .scanTag   (scanTag),
        .ramData   (ramData),
        .peakValid (peakValid),
        .peak      (peak)
    );

endmodule

// File: sim/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;
    localparam int RST_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: sim/sifhTb.sv
`timescale 1ns/1ps

module sifhTb import sifhPkg::*; ();

    localparam int FRAME_LEN = PIXEL_NUM * ACQ_NUM;
    localparam int FRAME_NUM = 4;
    localparam int DRIVE_DLY = 1;
    // bins per pixel, one scan read each
    localparam int PEAK_GAP = BIN_NUM;
    // worst case with gaps, plus drain and scan
    localparam int FRAME_CYC = 2 * FRAME_LEN + RAM_DEPTH;
    localparam int LIMIT_CYC = RAM_DEPTH + FRAME_NUM * (FRAME_CYC + 120);

    typedef peakT [PIXEL_NUM-1:0] peakSetT;

    logic  clk;
    logic  rst;
    logic  sampleValid;
    stampT sample;
    logic  ready;
    logic  peakValid;
    peakT  peak;

    // stamps of the frame being offered
    stampT frameStamps [FRAME_LEN];
    // expected results, in arrival order
    peakT  expQ [$];

    int valueErrors = 0;
    int otherErrors = 0;
    int peaksSeen = 0;
    int cycleNow = 0;
    int lastPulse = 0;

    clockGen clocks (
        .clk (clk),
        .rst (rst)
    );

    sifhTop uut (
        .clk         (clk),
        .rst         (rst),
        .sampleValid (sampleValid),
        .sample      (sample),
        .ready       (ready),
        .peakValid   (peakValid),
        .peak        (peak)
    );

    // histogram per pixel, then the peak of each
    function automatic peakSetT refPeaks(input stampT stamps [FRAME_LEN]);
        peakSetT res;
        int hist [BIN_NUM];
        int b;
        int best;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int i = 0; i < BIN_NUM; i++) begin
                hist[i] = 0;
            end
            // bin is the top of the stamp, counts stop at the max
            for (int k = 0; k < ACQ_NUM; k++) begin
                b = int'(stamps[p * ACQ_NUM + k] >> (STAMP_W - BIN_W));
                if (hist[b] < COUNT_MAX) begin
                    hist[b]++;
                end
            end
            // strict compare, so a tie keeps the lowest bin
            best = 0;
            for (int i = 1; i < BIN_NUM; i++) begin
                if (hist[i] > hist[best]) begin
                    best = i;
                end
            end
            res[p].pixel = pixelT'(p);
            res[p].bin   = binT'(best);
            res[p].count = countT'(hist[best]);
        end
        return res;
    endfunction

    // random stamp forced into one bin
    function automatic stampT stampInBin(input int bin);
        stampT s;
        s = stampT'($urandom);
        s[STAMP_W-1 -: BIN_W] = binT'(bin);
        return s;
    endfunction

    task automatic buildRandomFrame();
        for (int i = 0; i < FRAME_LEN; i++) begin
            frameStamps[i] = stampT'($urandom);
        end
    endtask

    task automatic buildCornerFrame();
        int base;
        // pixel 0: one bin, 80 hits, saturates
        for (int k = 0; k < ACQ_NUM; k++) begin
            frameStamps[k] = stampInBin(13);
        end
        // pixel 1: bins 11 and 5 tie at 35, higher bin seen first
        base = ACQ_NUM;
        for (int k = 0; k < 70; k++) begin
            frameStamps[base + k] = stampInBin((k % 2 == 0) ? 11 : 5);
        end
        for (int k = 70; k < ACQ_NUM; k++) begin
            frameStamps[base + k] = stampInBin(k % 3);
        end
        // pixel 2: two runs of 40, bin 7 then bin 2
        base = 2 * ACQ_NUM;
        for (int k = 0; k < ACQ_NUM; k++) begin
            frameStamps[base + k] = stampInBin((k < 40) ? 7 : 2);
        end
        // pixel 3: alternating pair, then a long run
        base = 3 * ACQ_NUM;
        for (int k = 0; k < ACQ_NUM; k++) begin
            frameStamps[base + k] = stampInBin((k < 50 && k % 2 == 1) ? 1 : 14);
        end
    endtask

    task automatic checkValue(input string name, input int got, input int want);
        assert (got == want) else begin
            valueErrors++;
            $display("[ERROR] %s: got %0h, expected %0h", name, got, want);
        end
    endtask

    task automatic printCounts();
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
    endtask

    // offer one frame; junk goes out whenever ready is low
    task automatic feedFrame(input bit gaps);
        int idx;
        idx = 0;
        while (idx < FRAME_LEN) begin
            @(posedge clk);
            #(DRIVE_DLY);
            // ready now holds until the next edge
            if (!ready) begin
                sampleValid = 1'b1;
                sample      = stampT'($urandom);
            end else if (gaps && ($urandom % 4 == 0)) begin
                sampleValid = 1'b0;
                sample      = stampT'($urandom);
            end else begin
                sampleValid = 1'b1;
                sample      = frameStamps[idx];
                idx++;
            end
        end
        @(posedge clk);
        #(DRIVE_DLY);
        sampleValid = 1'b0;
        assert (!ready) else begin
            otherErrors++;
            $display("ready still high after the last sample of a frame");
        end
    endtask

    task automatic runFrame(input bit corner, input bit gaps);
        peakSetT exp;
        if (corner) begin
            buildCornerFrame();
        end else begin
            buildRandomFrame();
        end
        exp = refPeaks(frameStamps);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expQ.push_back(exp[p]);
        end
        feedFrame(gaps);
    endtask

    // main sequence
    initial begin
        int clearCyc;
        void'($urandom(32'h53bc));
        sampleValid = 1'b0;
        sample      = '0;
        @(posedge clk);
        #(DRIVE_DLY);
        assert (!ready && !peakValid) else begin
            otherErrors++;
            $display("ready or peakValid high during reset");
        end
        // junk offered through reset and the clear
        sampleValid = 1'b1;
        sample      = stampT'($urandom);
        wait (!rst);
        clearCyc = 0;
        while (!ready) begin
            @(posedge clk);
            #(DRIVE_DLY);
            clearCyc++;
            sampleValid = !ready;
            sample      = stampT'($urandom);
        end
        checkValue("clearCycles", clearCyc, RAM_DEPTH);

        // random back to back, corners back to back, then both with gaps
        runFrame(1'b0, 1'b0);
        runFrame(1'b1, 1'b0);
        runFrame(1'b0, 1'b1);
        runFrame(1'b1, 1'b1);

        while (peaksSeen < FRAME_NUM * PIXEL_NUM) begin
            @(posedge clk);
        end
        #(DRIVE_DLY);
        assert (expQ.size() == 0) else begin
            otherErrors++;
            $display("fewer results than expected");
        end
        assert (ready) else begin
            otherErrors++;
            $display("ready did not return after the last scan");
        end

        printCounts();
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // compare each result at mid cycle
    initial begin
        peakT want;
        forever begin
            @(negedge clk);
            cycleNow++;
            if (peakValid) begin
                if (expQ.size() == 0) begin
                    otherErrors++;
                    $display("peakValid pulsed with no result expected");
                end else begin
                    want = expQ.pop_front();
                    checkValue("peak.pixel", int'(peak.pixel), int'(want.pixel));
                    checkValue("peak.bin", int'(peak.bin), int'(want.bin));
                    checkValue("peak.count", int'(peak.count), int'(want.count));
                    // pixels after the first follow at one scan row each
                    if (want.pixel != '0) begin
                        assert (cycleNow - lastPulse == PEAK_GAP) else begin
                            otherErrors++;
                            $display("peakValid pulses %0d cycles apart, expected %0d",
                                     cycleNow - lastPulse, PEAK_GAP);
                        end
                    end
                end
                lastPulse = cycleNow;
                peaksSeen++;
            end
        end
    end

    // watchdog
    initial begin
        repeat (LIMIT_CYC) @(posedge clk);
        $display("timeout after %0d cycles, results still missing", LIMIT_CYC);
        printCounts();
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: filelist.f
logic/sifhPkg.sv
logic/histRam.sv
logic/countUpdater.sv
logic/peakFinder.sv
logic/histControl.sv
logic/sifhTop.sv
sim/clockGen.sv
sim/sifhTb.sv

// File: Makefile
VERILATOR = verilator
TOP       = sifhTb
FILELIST  = filelist.f
OBJDIR    = obj_dir
LINTFLAGS = --lint-only --timing --assert
SIMFLAGS  = --binary --timing --assert -j 0
PASSMSG   = Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASSMSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)
